// ==== dv/tbDscrptrFetch.sv ====
// Self-checking testbench for the descriptor fetch controller, compiled from the file list
`include "dscrptrFetch_consts.svh"

module tbDscrptrFetch;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int kindExt  = 0;
    localparam int kindRdy  = 1;
    localparam int kindStr  = 2;
    localparam int kindBoth = 3;

    logic clock, resetn, fetchExtDscrptr, extRdyCheck, strDscrptrValid;
    logic extFetchValid, rdDscrptrValid, ldExtDscrptrAck;
    logic [`ADDR_WIDTH-1:0] extDscrptrAddrIn, strDscrptrAddr, strtAddr, extDscrptrAddr;
    logic [`NUM_INT_BDS_WIDTH-1:0] intDscrptrNumIn, intDscrptrNum;
    logic [`DSCRPTR_WIDTH-1:0] rdDscrptrData, dscrptrData;
    logic [1:0] rdDataValid;
    logic strtExtDscrptrRd, strtExtDscrptrRdyCheck, strtStrDscrptrRd, strFetchHoldOff;
    logic extRdyValid, extRdy, extFetchDone, strDscrptrAck, strDscrptrAckValid;
    logic ldExtDscrptr, strDcrptr, dataValid, dscrptrValid;

    // Planned response and expected load contents of the running transaction
    logic [31:0] lfsr;
    logic [`DSCRPTR_WIDTH-1:0] planData, expData;
    logic [1:0] planDv;
    logic [`ADDR_WIDTH-1:0] reqAddr, expStrtAddr;
    logic [`NUM_INT_BDS_WIDTH-1:0] expNum;
    logic planDsc, expStream, expDv, expRdy, isRdy, sawRequest;
    logic cmdSeen, loadSeen, ackWas;
    int respDelay, ackDelay, busCount, ackCount, mismatchCount, failCount;

    dscrptrFetchTop dut (.*);

    always #20 clock = ~clock;

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output logic [`DSCRPTR_WIDTH-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsrNext(lfsr);
            v = {v[`DSCRPTR_WIDTH-2:0], lfsr[0]};
        end
    endtask

    // External word with the data-valid flag replaced
    function automatic logic [`DSCRPTR_WIDTH-1:0] withValid(
        input logic [`DSCRPTR_WIDTH-1:0] w,
        input logic v
    );
        logic [`DSCRPTR_WIDTH-1:0] r;
        r = w;
        r[`DATA_VALID_BIT] = v;
        return r;
    endfunction

    task automatic reportMismatch(input string name, input logic [`DSCRPTR_WIDTH-1:0] got,
                                  input logic [`DSCRPTR_WIDTH-1:0] exp);
        mismatchCount++;
        $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic reportFailure(input string what);
        failCount++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic waitDone(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < 60)
        begin
            @(negedge clock);
            ok = extRdyValid | extFetchDone | strDscrptrAck;
            cycles++;
        end
        if (!ok)
            reportFailure("timeout waiting for the transaction to finish");
    endtask

    ////////////////////////////////////////////////////////////
    // Bus initiator and consumer models
    ////////////////////////////////////////////////////////////
    always @(negedge clock)
    begin
        cmdSeen = strtExtDscrptrRd | strtExtDscrptrRdyCheck | strtStrDscrptrRd;
        @(posedge clock);
        #2;
        if (!resetn || !cmdSeen)
        begin
            extFetchValid = 1'b0;
            rdDscrptrData = '0;
            busCount = respDelay;
        end
        else if (busCount == 0)
        begin
            extFetchValid = 1'b1;
            rdDscrptrData = planData;
            rdDataValid = planDv;
            rdDscrptrValid = planDsc;
        end
        else
            busCount--;
    end

    // Ack held until the release cycle
    always @(negedge clock)
    begin
        loadSeen = ldExtDscrptr;
        ackWas = ldExtDscrptrAck;
        @(posedge clock);
        #2;
        if (!resetn || !loadSeen || ackWas)
        begin
            ldExtDscrptrAck = 1'b0;
            ackCount = ackDelay;
        end
        else if (ackCount == 0)
            ldExtDscrptrAck = 1'b1;
        else
            ackCount--;
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    assign expStrtAddr = reqAddr + (isRdy ? 32'd1 : 32'd0);

    loadData: assert property (@(posedge clock) $rose(ldExtDscrptr) |-> dscrptrData == expData)
        else reportMismatch("dscrptrData", $sampled(dscrptrData), expData);
    loadAddr: assert property (@(posedge clock) $rose(ldExtDscrptr) |-> extDscrptrAddr == reqAddr)
        else reportMismatch("extDscrptrAddr", $sampled(extDscrptrAddr), reqAddr);
    loadNum: assert property (@(posedge clock) $rose(ldExtDscrptr) |-> intDscrptrNum == expNum)
        else reportMismatch("intDscrptrNum", $sampled(intDscrptrNum), expNum);
    loadStream: assert property (@(posedge clock) $rose(ldExtDscrptr) |-> strDcrptr == expStream)
        else reportMismatch("strDcrptr", $sampled(strDcrptr), expStream);
    loadDv: assert property (@(posedge clock) $rose(ldExtDscrptr) |-> dataValid == expDv)
        else reportMismatch("dataValid", $sampled(dataValid), expDv);
    loadDsc: assert property (@(posedge clock) $rose(ldExtDscrptr) |-> dscrptrValid == planDsc)
        else reportMismatch("dscrptrValid", $sampled(dscrptrValid), planDsc);
    loadFollows: assert property (@(posedge clock) extFetchValid |=> ldExtDscrptr == !isRdy)
        else reportFailure("load presence after read completion is wrong");
    holdStable: assert property (@(posedge clock) ldExtDscrptr && !ldExtDscrptrAck
        |=> ldExtDscrptr && $stable(dscrptrData)) else reportFailure("load changed without ack");
    clearAfterAck: assert property (@(posedge clock) ldExtDscrptr && ldExtDscrptrAck
        |=> !ldExtDscrptr && !strDcrptr && !dataValid && !dscrptrValid && dscrptrData == '0
            && intDscrptrNum == '0 && extDscrptrAddr == '0)
        else reportFailure("load outputs not cleared after ack");
    ackStrobes: assert property (@(posedge clock) ldExtDscrptr && ldExtDscrptrAck
        |-> extFetchDone == !expStream && strDscrptrAck == expStream)
        else reportFailure("completion strobe missing or wrong at ack");
    ackValid: assert property (@(posedge clock) ldExtDscrptr && ldExtDscrptrAck && expStream
        |-> strDscrptrAckValid == planDsc)
        else reportMismatch("strDscrptrAckValid", $sampled(strDscrptrAckValid), planDsc);
    rdyStrobe: assert property (@(posedge clock) extFetchValid && isRdy |-> extRdyValid)
        else reportFailure("ready check completed without extRdyValid");
    rdyResult: assert property (@(posedge clock) extRdyValid |-> extRdy == expRdy)
        else reportMismatch("extRdy", $sampled(extRdy), expRdy);
    rdyCmd: assert property (@(posedge clock) extRdyCheck && !fetchExtDscrptr
        |-> strtExtDscrptrRdyCheck && !strFetchHoldOff)
        else reportFailure("ready check command not issued");
    cmdAddr: assert property (@(posedge clock)
        (strtExtDscrptrRd || strtExtDscrptrRdyCheck || strtStrDscrptrRd)
        |-> strtAddr == expStrtAddr)
        else reportMismatch("strtAddr", $sampled(strtAddr), $sampled(expStrtAddr));
    extFirst: assert property (@(posedge clock) fetchExtDscrptr
        |-> strtExtDscrptrRd && !strFetchHoldOff)
        else reportFailure("external request did not win arbitration");
    strHoldOff: assert property (@(posedge clock)
        strDscrptrValid && !fetchExtDscrptr && !extRdyCheck
        |-> strtStrDscrptrRd && strFetchHoldOff) else reportFailure("stream read not issued");
    quietAfterReset: assert property (@(posedge clock) !sawRequest
        |-> !(strtExtDscrptrRd || strtExtDscrptrRdyCheck || strtStrDscrptrRd || extRdyValid
            || extFetchDone || strDscrptrAck || ldExtDscrptr))
        else reportFailure("output active before any request");

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial
    begin
        bit ok;
        int kind;
        logic [`DSCRPTR_WIDTH-1:0] rnd;
        clock = 1'b0;
        resetn = 1'b0;
        fetchExtDscrptr = 1'b0;
        extRdyCheck = 1'b0;
        strDscrptrValid = 1'b0;
        extFetchValid = 1'b0;
        rdDscrptrValid = 1'b0;
        ldExtDscrptrAck = 1'b0;
        extDscrptrAddrIn = '0;
        strDscrptrAddr = '0;
        intDscrptrNumIn = '0;
        rdDscrptrData = '0;
        rdDataValid = '0;
        lfsr = 32'ha516_093f;
        {planData, expData, planDv, planDsc, reqAddr, expNum} = '0;
        {expStream, expDv, expRdy, isRdy, sawRequest} = '0;
        {respDelay, ackDelay, busCount, ackCount, mismatchCount, failCount} = '0;
        repeat (5) @(posedge clock);
        #2;
        resetn = 1'b1;
        ok = 1'b1;
        for (int txn = 0; txn < 60 && ok; txn++)
        begin
            repeat (2) @(posedge clock);
            #2;
            // First four cover each kind once
            drawBits(2, rnd);
            kind = (txn < 4) ? txn : rnd[1:0];
            drawBits(8, rnd);
            respDelay = rnd[7:0] % 6;
            drawBits(8, rnd);
            ackDelay = rnd[7:0] % 6;
            drawBits(32, rnd);
            extDscrptrAddrIn = rnd[31:0];
            drawBits(32, rnd);
            strDscrptrAddr = rnd[31:0];
            drawBits(2, rnd);
            intDscrptrNumIn = rnd[1:0];
            drawBits(`DSCRPTR_WIDTH, planData);
            drawBits(3, rnd);
            planDv = rnd[1:0];
            planDsc = rnd[2];
            expStream = (kind == kindStr);
            isRdy = (kind == kindRdy);
            reqAddr = expStream ? strDscrptrAddr : extDscrptrAddrIn;
            expNum = expStream ? '0 : intDscrptrNumIn;
            expDv = expStream ? planDv[0] : &planDv;
            expRdy = &planDv;
            expData = expStream ? planData : withValid(planData, &planDv);
            @(posedge clock);
            #2;
            sawRequest = 1'b1;
            fetchExtDscrptr = (kind == kindExt) || (kind == kindBoth);
            extRdyCheck = (kind == kindRdy);
            strDscrptrValid = (kind == kindStr) || (kind == kindBoth);
            @(posedge clock);
            #2;
            fetchExtDscrptr = 1'b0;
            extRdyCheck = 1'b0;
            strDscrptrValid = 1'b0;
            waitDone(ok);
        end
        repeat (2) @(posedge clock);
        $display("Run ended with %0d mismatches and %0d other errors", mismatchCount, failCount);
        if (mismatchCount + failCount == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/dscrptrFetchPkg.sv
hdl/dscrptrLoadIf.sv
hdl/dscrptrFetchFsm.sv
hdl/dscrptrHoldStage.sv
hdl/dscrptrFetchTop.sv
dv/tbDscrptrFetch.sv

// ==== hdl/dscrptrFetchFsm.sv ====
// Arbitrates descriptor requests and sequences one bus read and load at a time
`include "dscrptrFetch_consts.svh"

module dscrptrFetchFsm (
    input  logic                          clock,
    input  logic                          resetn,
    // Requests
    input  logic                          fetchExtDscrptr,
    input  logic                          extRdyCheck,
    input  logic                          strDscrptrValid,
    input  logic [`ADDR_WIDTH-1:0]        extDscrptrAddrIn,
    input  logic [`ADDR_WIDTH-1:0]        strDscrptrAddr,
    input  logic [`NUM_INT_BDS_WIDTH-1:0] intDscrptrNumIn,
    // Read return
    input  logic                          extFetchValid,
    input  logic                          rdDscrptrValid,
    input  logic [`DSCRPTR_WIDTH-1:0]     rdDscrptrData,
    input  logic [1:0]                    rdDataValid,
    input  logic                          ldExtDscrptrAck,
    // Read command
    output logic                          strtExtDscrptrRd,
    output logic                          strtExtDscrptrRdyCheck,
    output logic                          strtStrDscrptrRd,
    output logic [`ADDR_WIDTH-1:0]        strtAddr,
    output logic                          strFetchHoldOff,
    // Completion strobes
    output logic                          extRdyValid,
    output logic                          extRdy,
    output logic                          extFetchDone,
    output logic                          strDscrptrAck,
    dscrptrLoadIf.fsm                     load
);
    import dscrptrFetchPkg::*;

    fetchState_e currState;
    fetchState_e nextState;
    logic [2:0]  cmdVec;

    ////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            currState <= IDLE;
        end
        else
        begin
            currState <= nextState;
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state and command decode
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        nextState              = currState;
        strtExtDscrptrRd       = 1'b0;
        strtExtDscrptrRdyCheck = 1'b0;
        strtStrDscrptrRd       = 1'b0;
        strtAddr               = '0;
        extRdyValid            = 1'b0;
        extRdy                 = 1'b0;
        extFetchDone           = 1'b0;
        strDscrptrAck          = 1'b0;
        load.capture           = 1'b0;
        load.releaseLd         = 1'b0;
        case (currState)
            IDLE:
            begin
                // External fetch wins, then ready check, then stream
                if (fetchExtDscrptr)
                begin
                    strtExtDscrptrRd = 1'b1;
                    strtAddr         = extDscrptrAddrIn;
                    nextState        = EXT_FETCH_WAIT;
                end
                else if (extRdyCheck)
                begin
                    strtExtDscrptrRdyCheck = 1'b1;
                    strtAddr               = extDscrptrAddrIn + `CONFIG_BYTE2_OFFSET;
                    nextState              = EXT_VALID_CHECK;
                end
                else if (strDscrptrValid)
                begin
                    strtStrDscrptrRd = 1'b1;
                    strtAddr         = strDscrptrAddr;
                    nextState        = STR_FETCH_WAIT;
                end
            end
            EXT_FETCH_WAIT:
            begin
                if (extFetchValid)
                begin
                    load.capture = 1'b1;
                    nextState    = EXT_FETCH_STORE;
                end
                else
                begin
                    strtExtDscrptrRd = 1'b1;
                    strtAddr         = extDscrptrAddrIn;
                end
            end
            EXT_VALID_CHECK:
            begin
                if (extFetchValid)
                begin
                    extRdyValid = 1'b1;
                    extRdy      = &rdDataValid;
                    nextState   = IDLE;
                end
                else
                begin
                    strtExtDscrptrRdyCheck = 1'b1;
                    strtAddr               = extDscrptrAddrIn + `CONFIG_BYTE2_OFFSET;
                end
            end
            STR_FETCH_WAIT:
            begin
                if (extFetchValid)
                begin
                    load.capture = 1'b1;
                    nextState    = STR_FETCH_STORE;
                end
                else
                begin
                    strtStrDscrptrRd = 1'b1;
                    strtAddr         = strDscrptrAddr;
                end
            end
            EXT_FETCH_STORE, STR_FETCH_STORE:
            begin
                // Consumer back-pressure holds the load until acknowledged
                if (ldExtDscrptrAck)
                begin
                    load.releaseLd = 1'b1;
                    extFetchDone   = (currState == EXT_FETCH_STORE);
                    strDscrptrAck  = (currState == STR_FETCH_STORE);
                    nextState      = IDLE;
                end
            end
            default:
            begin
                nextState = IDLE;
            end
        endcase
    end

    assign strFetchHoldOff = strtStrDscrptrRd;

    // Capture contents; the hold stage samples these only on capture
    assign load.streamSel = (currState == STR_FETCH_WAIT);
    assign load.validBit  = load.streamSel ? rdDataValid[0] : &rdDataValid;
    assign load.intNum    = load.streamSel ? '0 : intDscrptrNumIn;
    assign load.addr      = load.streamSel ? strDscrptrAddr : extDscrptrAddrIn;
    assign load.word.raw  = rdDscrptrData;
    assign load.dscValid  = rdDscrptrValid;

    ////////////////////////////////////////////////////////////
    // Command checks
    ////////////////////////////////////////////////////////////
    assign cmdVec = {strtExtDscrptrRd, strtExtDscrptrRdyCheck, strtStrDscrptrRd};

    // Completed command must not reappear in the next cycle
    cmdDropsAfterDone: assert property (@(posedge clock) disable iff (!resetn)
        ((|cmdVec) ##1 extFetchValid) |=> ((cmdVec & $past(cmdVec, 2)) == 3'b000));

    cmdOneHot: assert property (@(posedge clock) disable iff (!resetn)
        $onehot0(cmdVec));

endmodule

// ==== hdl/dscrptrFetchPkg.sv ====
// Descriptor word views and FSM state encoding shared by the fetch FSM and hold stage
`include "dscrptrFetch_consts.svh"

package dscrptrFetchPkg;

    // Field view with the MSB first
    typedef struct packed {
        logic [`DSCRPTR_WIDTH-`DATA_VALID_BIT-2:0] payload;
        logic                                     dataValid;
        logic [`DATA_VALID_BIT-1:0]               cfgLow;
    } dscrptrFields_s;

    // Stream descriptors pass raw
    // External ones go through the field view to patch the valid flag
    typedef union packed {
        logic [`DSCRPTR_WIDTH-1:0] raw;
        dscrptrFields_s            fields;
    } dscrptrWord_u;

    // One-hot sequencing states
    typedef enum logic [5:0] {
        IDLE            = 6'b000001,
        EXT_FETCH_WAIT  = 6'b000010,
        EXT_FETCH_STORE = 6'b000100,
        EXT_VALID_CHECK = 6'b001000,
        STR_FETCH_WAIT  = 6'b010000,
        STR_FETCH_STORE = 6'b100000
    } fetchState_e;

endpackage

// ==== hdl/dscrptrFetchTop.sv ====
// Descriptor fetch controller top level; instantiate with plain ports in the DMA engine
`include "dscrptrFetch_consts.svh"

module dscrptrFetchTop (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          fetchExtDscrptr,
    input  logic                          extRdyCheck,
    input  logic                          strDscrptrValid,
    input  logic                          extFetchValid,
    input  logic                          rdDscrptrValid,
    input  logic                          ldExtDscrptrAck,
    input  logic [`ADDR_WIDTH-1:0]        extDscrptrAddrIn,
    input  logic [`ADDR_WIDTH-1:0]        strDscrptrAddr,
    input  logic [`NUM_INT_BDS_WIDTH-1:0] intDscrptrNumIn,
    input  logic [`DSCRPTR_WIDTH-1:0]     rdDscrptrData,
    input  logic [1:0]                    rdDataValid,
    output logic                          strtExtDscrptrRd,
    output logic                          strtExtDscrptrRdyCheck,
    output logic                          strtStrDscrptrRd,
    output logic                          strFetchHoldOff,
    output logic [`ADDR_WIDTH-1:0]        strtAddr,
    output logic                          extRdyValid,
    output logic                          extRdy,
    output logic                          extFetchDone,
    output logic                          strDscrptrAck,
    output logic                          strDscrptrAckValid,
    output logic                          ldExtDscrptr,
    output logic                          strDcrptr,
    output logic                          dataValid,
    output logic                          dscrptrValid,
    output logic [`DSCRPTR_WIDTH-1:0]     dscrptrData,
    output logic [`NUM_INT_BDS_WIDTH-1:0] intDscrptrNum,
    output logic [`ADDR_WIDTH-1:0]        extDscrptrAddr
);

    dscrptrLoadIf loadBus ();

    // Sequencing and bus command
    dscrptrFetchFsm uFsm (
        .clock                  (clock),
        .resetn                 (resetn),
        .fetchExtDscrptr        (fetchExtDscrptr),
        .extRdyCheck            (extRdyCheck),
        .strDscrptrValid        (strDscrptrValid),
        .extDscrptrAddrIn       (extDscrptrAddrIn),
        .strDscrptrAddr         (strDscrptrAddr),
        .intDscrptrNumIn        (intDscrptrNumIn),
        .extFetchValid          (extFetchValid),
        .rdDscrptrValid         (rdDscrptrValid),
        .rdDscrptrData          (rdDscrptrData),
        .rdDataValid            (rdDataValid),
        .ldExtDscrptrAck        (ldExtDscrptrAck),
        .strtExtDscrptrRd       (strtExtDscrptrRd),
        .strtExtDscrptrRdyCheck (strtExtDscrptrRdyCheck),
        .strtStrDscrptrRd       (strtStrDscrptrRd),
        .strtAddr               (strtAddr),
        .strFetchHoldOff        (strFetchHoldOff),
        .extRdyValid            (extRdyValid),
        .extRdy                 (extRdy),
        .extFetchDone           (extFetchDone),
        .strDscrptrAck          (strDscrptrAck),
        .load                   (loadBus.fsm)
    );

    // Descriptor presented to the consumer
    dscrptrHoldStage uHold (
        .clock              (clock),
        .resetn             (resetn),
        .load               (loadBus.hold),
        .ldExtDscrptr       (ldExtDscrptr),
        .strDcrptr          (strDcrptr),
        .dataValid          (dataValid),
        .dscrptrValid       (dscrptrValid),
        .dscrptrData        (dscrptrData),
        .intDscrptrNum      (intDscrptrNum),
        .extDscrptrAddr     (extDscrptrAddr),
        .strDscrptrAckValid (strDscrptrAckValid)
    );

endmodule

// ==== hdl/dscrptrFetch_consts.svh ====
// Widths and field positions for descriptor fetch, included by the package and every RTL file
`ifndef DSCRPTR_FETCH_CONSTS_SVH
`define DSCRPTR_FETCH_CONSTS_SVH

// Full descriptor word as returned by the bus initiator
`define DSCRPTR_WIDTH 133

// Descriptor address width
`define ADDR_WIDTH 32

// Internal descriptor number
`define NUM_INT_BDS_WIDTH 2

// Ready check reads the second config byte, so the address is offset by one byte
`define CONFIG_BYTE2_OFFSET 1

// Position of the data-valid flag inside the config field
`define DATA_VALID_BIT 13

`endif

// ==== hdl/dscrptrHoldStage.sv ====
// Holds a captured descriptor and presents it to the consumer until release
`include "dscrptrFetch_consts.svh"

module dscrptrHoldStage (
    input  logic                          clock,
    input  logic                          resetn,
    dscrptrLoadIf.hold                    load,
    output logic                          ldExtDscrptr,
    output logic                          strDcrptr,
    output logic                          dataValid,
    output logic                          dscrptrValid,
    output logic [`DSCRPTR_WIDTH-1:0]     dscrptrData,
    output logic [`NUM_INT_BDS_WIDTH-1:0] intDscrptrNum,
    output logic [`ADDR_WIDTH-1:0]        extDscrptrAddr,
    output logic                          strDscrptrAckValid
);
    import dscrptrFetchPkg::*;

    dscrptrWord_u mergedWord;
    dscrptrWord_u heldWord;

    // External descriptors carry the combined valid bit in the config field
    always_comb
    begin
        mergedWord = load.word;
        if (!load.streamSel)
        begin
            mergedWord.fields.dataValid = load.validBit;
        end
    end

    ////////////////////////////////////////////////////////////
    // Holding registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            ldExtDscrptr   <= 1'b0;
            strDcrptr      <= 1'b0;
            dataValid      <= 1'b0;
            dscrptrValid   <= 1'b0;
            heldWord       <= '0;
            intDscrptrNum  <= '0;
            extDscrptrAddr <= '0;
        end
        else if (load.capture)
        begin
            ldExtDscrptr   <= 1'b1;
            strDcrptr      <= load.streamSel;
            dataValid      <= load.validBit;
            dscrptrValid   <= load.dscValid;
            heldWord       <= mergedWord;
            intDscrptrNum  <= load.intNum;
            extDscrptrAddr <= load.addr;
        end
        else if (load.releaseLd)
        begin
            // Consumer took it so outputs return to zero
            ldExtDscrptr   <= 1'b0;
            strDcrptr      <= 1'b0;
            dataValid      <= 1'b0;
            dscrptrValid   <= 1'b0;
            heldWord       <= '0;
            intDscrptrNum  <= '0;
            extDscrptrAddr <= '0;
        end
    end

    assign dscrptrData = heldWord.raw;

    // Reports the stream descriptor's valid flag back with the ack
    assign strDscrptrAckValid = load.releaseLd && strDcrptr && dscrptrValid;

    ////////////////////////////////////////////////////////////
    // Handshake checks
    ////////////////////////////////////////////////////////////
    captureWhenEmpty: assert property (@(posedge clock) disable iff (!resetn)
        load.capture |-> !ldExtDscrptr);

    releaseWhenLoaded: assert property (@(posedge clock) disable iff (!resetn)
        load.releaseLd |-> ldExtDscrptr);

endmodule

// ==== hdl/dscrptrLoadIf.sv ====
// Capture/release link that hands one fetched descriptor from the FSM to the hold stage
`include "dscrptrFetch_consts.svh"

interface dscrptrLoadIf;
    import dscrptrFetchPkg::*;

    // Handshake pulses with one release per capture
    logic                          capture;
    logic                          releaseLd;

    // Descriptor contents valid in the capture cycle
    logic                          streamSel;
    logic                          validBit;
    logic [`NUM_INT_BDS_WIDTH-1:0] intNum;
    logic [`ADDR_WIDTH-1:0]        addr;
    dscrptrWord_u                  word;
    logic                          dscValid;

    modport fsm (
        output capture, releaseLd, streamSel, validBit,
        output intNum, addr, word, dscValid
    );

    modport hold (
        input capture, releaseLd, streamSel, validBit,
        input intNum, addr, word, dscValid
    );

endinterface
